//--- rtl/wavegen_cfg.svh
`ifndef WAVEGEN_CFG_SVH
`define WAVEGEN_CFG_SVH

// AXI4-Lite bus geometry, 16 words
`define WG_ADDR_W       6
`define WG_DATA_W       32
`define WG_STRB_W       (`WG_DATA_W / 8)

// Word index field inside the byte address
`define WG_IDX_MSB      5
`define WG_IDX_LSB      2

// Channel field widths
`define WG_SAMPLE_W     16
`define WG_FREQ_W       32
`define WG_MODE_W       4
// Q1.15 amplitude, fraction bits
`define WG_AMP_FRAC     15

// Reset defaults
`define WG_MODE_RESET   4'h0
`define WG_FREQ_RESET   32'h0000_0000
`define WG_OFFSET_RESET 16'h0000
`define WG_AMP_RESET    16'h7FFF

// STATUS bit of the always-set ready flag
`define WG_STATUS_READY 0

`endif

//--- rtl/wavegen_axi_pkg.sv
`include "wavegen_cfg.svh"

package wavegen_axi_pkg;

    // Bus-side vectors
    typedef logic [`WG_ADDR_W-1:0] axi_addr_t;
    typedef logic [`WG_DATA_W-1:0] axi_data_t;
    typedef logic [`WG_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]            axi_resp_t;

    // Only response this slave ever gives
    localparam axi_resp_t RESP_OKAY = 2'b00;

    // Word index, 6 to 10 reserved
    typedef enum logic [3:0] {
        MODE     = 4'd0,
        RUN      = 4'd1,
        FREQ_A   = 4'd2,
        FREQ_B   = 4'd3,
        OFFSET   = 4'd4,
        AMPLTD   = 4'd5,
        RECONFIG = 4'd11,
        STATUS   = 4'd12,
        TRIGGER  = 4'd13
    } reg_idx_e;

    // AXI slave FSM
    typedef enum logic [2:0] {
        IDLE,
        WR_ACCEPT,
        WR_RESP,
        RD_ACCEPT,
        RD_DATA
    } slave_state_e;

endpackage

//--- rtl/wavegen_chan_pkg.sv
`include "wavegen_cfg.svh"

package wavegen_chan_pkg;

    // Raw and scaled samples, two's complement
    typedef logic signed [`WG_SAMPLE_W-1:0] sample_t;

    // Amplitude, unsigned Q1.15
    typedef logic [`WG_SAMPLE_W-1:0] amp_t;

    // DC offset added after scaling
    typedef logic signed [`WG_SAMPLE_W-1:0] offset_t;

    // Frequency word, 100 uHz per LSB
    typedef logic [`WG_FREQ_W-1:0] freq_t;

    // Waveform selector for the external core
    typedef logic [`WG_MODE_W-1:0] mode_t;

endpackage

//--- rtl/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if;
    import wavegen_axi_pkg::*;

    // Write port, one-cycle strobe per accepted write
    logic      wr_en;
    reg_idx_e  wr_idx;
    axi_data_t wr_data;
    axi_strb_t wr_strb;

    // Read port, data follows index combinationally
    reg_idx_e  rd_idx;
    axi_data_t rd_data;

    modport master (
        output wr_en, wr_idx, wr_data, wr_strb, rd_idx,
        input  rd_data
    );

    modport target (
        input  wr_en, wr_idx, wr_data, wr_strb, rd_idx,
        output rd_data
    );

endinterface

//--- rtl/wavegen_axi_slave.sv
`timescale 1ns/1ps
`include "wavegen_cfg.svh"

module wavegen_axi_slave (
    input  logic                      axi_clk,
    input  logic                      axi_resetn,
    input  wavegen_axi_pkg::axi_addr_t awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  wavegen_axi_pkg::axi_data_t wdata,
    input  wavegen_axi_pkg::axi_strb_t wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output wavegen_axi_pkg::axi_resp_t bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  wavegen_axi_pkg::axi_addr_t araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output wavegen_axi_pkg::axi_data_t rdata,
    output wavegen_axi_pkg::axi_resp_t rresp,
    output logic                      rvalid,
    input  logic                      rready,
    reg_bus_if.master                 bus
);
    import wavegen_axi_pkg::*;

    slave_state_e state;
    slave_state_e state_nxt;
    reg_idx_e     wr_idx_q;
    reg_idx_e     rd_idx_q;
    logic         wr_start;
    logic         rd_start;

    // ==================================================
    // FSM
    // ==================================================

    // Write needs address and data together, wins over read
    assign wr_start = (state == IDLE) && awvalid && wvalid;
    assign rd_start = (state == IDLE) && arvalid && !wr_start;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (wr_start)
                    state_nxt = WR_ACCEPT;
                else if (rd_start)
                    state_nxt = RD_ACCEPT;
            end
            WR_ACCEPT: state_nxt = WR_RESP;
            // Hold response until master takes it
            WR_RESP:   if (bready) state_nxt = IDLE;
            RD_ACCEPT: state_nxt = RD_DATA;
            RD_DATA:   if (rready) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // Word index capture on acceptance
    always_ff @(posedge axi_clk) begin
        if (wr_start)
            wr_idx_q <= reg_idx_e'(awaddr[`WG_IDX_MSB:`WG_IDX_LSB]);
        if (rd_start)
            rd_idx_q <= reg_idx_e'(araddr[`WG_IDX_MSB:`WG_IDX_LSB]);
    end

    // Read data sampled in the accept cycle
    always_ff @(posedge axi_clk) begin
        if (state == RD_ACCEPT)
            rdata <= bus.rd_data;
    end

    // ==================================================
    // Handshake outputs
    // ==================================================
    assign awready = (state == WR_ACCEPT);
    assign wready  = (state == WR_ACCEPT);
    assign bvalid  = (state == WR_RESP);
    assign bresp   = RESP_OKAY;
    assign arready = (state == RD_ACCEPT);
    assign rvalid  = (state == RD_DATA);
    assign rresp   = RESP_OKAY;

    // Register bus, wdata still held by the master in WR_ACCEPT
    assign bus.wr_en   = (state == WR_ACCEPT);
    assign bus.wr_idx  = wr_idx_q;
    assign bus.wr_data = wdata;
    assign bus.wr_strb = wstrb;
    assign bus.rd_idx  = rd_idx_q;

    // Responses stay up until taken
    a_bvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        bvalid && !bready |=> bvalid)
        else $error("ERROR %0t: bvalid dropped before bready", $time);

    a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        rvalid && !rready |=> rvalid)
        else $error("ERROR %0t: rvalid dropped before rready", $time);

    // Register write only with both channels still offered
    a_wr_en_accept: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        bus.wr_en |-> state == WR_ACCEPT && awvalid && wvalid)
        else $error("ERROR %0t: wr_en outside an accepted write", $time);

endmodule

//--- rtl/wavegen_regs.sv
`timescale 1ns/1ps
`include "wavegen_cfg.svh"

module wavegen_regs (
    input  logic                      axi_clk,
    input  logic                      axi_resetn,
    reg_bus_if.target                 bus,
    output wavegen_chan_pkg::mode_t   mode_a,
    output wavegen_chan_pkg::mode_t   mode_b,
    output wavegen_chan_pkg::freq_t   freq_a,
    output wavegen_chan_pkg::freq_t   freq_b,
    output wavegen_chan_pkg::amp_t    amp_a,
    output wavegen_chan_pkg::amp_t    amp_b,
    output wavegen_chan_pkg::offset_t offset_a,
    output wavegen_chan_pkg::offset_t offset_b,
    output logic                      enable_a,
    output logic                      enable_b,
    output logic                      trigger_a,
    output logic                      trigger_b
);
    import wavegen_axi_pkg::*;
    import wavegen_chan_pkg::*;

    // Shadow copies, written by software
    mode_t   sh_mode_a, sh_mode_b;
    freq_t   sh_freq_a, sh_freq_b;
    offset_t sh_offset_a, sh_offset_b;
    amp_t    sh_amp_a, sh_amp_b;
    logic    sh_enable_a, sh_enable_b;

    // High for the one cycle in which shadow moves to active
    logic    reconfig_busy;

    // Byte-lane merge of a write into a word
    function automatic axi_data_t apply_strb(axi_data_t old_w, axi_data_t new_w,
                                             axi_strb_t strb);
        axi_data_t res;
        res = old_w;
        for (int b = 0; b < `WG_STRB_W; b++) begin
            if (strb[b])
                res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    // ==================================================
    // Write side
    // ==================================================
    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            sh_mode_a     <= `WG_MODE_RESET;
            sh_mode_b     <= `WG_MODE_RESET;
            sh_freq_a     <= `WG_FREQ_RESET;
            sh_freq_b     <= `WG_FREQ_RESET;
            sh_offset_a   <= `WG_OFFSET_RESET;
            sh_offset_b   <= `WG_OFFSET_RESET;
            sh_amp_a      <= `WG_AMP_RESET;
            sh_amp_b      <= `WG_AMP_RESET;
            sh_enable_a   <= 1'b0;
            sh_enable_b   <= 1'b0;
            mode_a        <= `WG_MODE_RESET;
            mode_b        <= `WG_MODE_RESET;
            freq_a        <= `WG_FREQ_RESET;
            freq_b        <= `WG_FREQ_RESET;
            offset_a      <= `WG_OFFSET_RESET;
            offset_b      <= `WG_OFFSET_RESET;
            amp_a         <= `WG_AMP_RESET;
            amp_b         <= `WG_AMP_RESET;
            enable_a      <= 1'b0;
            enable_b      <= 1'b0;
            reconfig_busy <= 1'b0;
            trigger_a     <= 1'b0;
            trigger_b     <= 1'b0;
        end else begin
            // Pulses clear by default
            trigger_a     <= 1'b0;
            trigger_b     <= 1'b0;
            reconfig_busy <= 1'b0;

            // Apply whole shadow set in one clock
            if (reconfig_busy) begin
                mode_a   <= sh_mode_a;
                mode_b   <= sh_mode_b;
                freq_a   <= sh_freq_a;
                freq_b   <= sh_freq_b;
                offset_a <= sh_offset_a;
                offset_b <= sh_offset_b;
                amp_a    <= sh_amp_a;
                amp_b    <= sh_amp_b;
                enable_a <= sh_enable_a;
                enable_b <= sh_enable_b;
            end

            // Later assignments win, so a RUN write beats the apply
            if (bus.wr_en) begin
                case (bus.wr_idx)
                    MODE: begin
                        if (bus.wr_strb[0])
                            {sh_mode_b, sh_mode_a} <= bus.wr_data[2*`WG_MODE_W-1:0];
                    end
                    RUN: begin
                        // Enables bypass the shadow stage
                        if (bus.wr_strb[0]) begin
                            {enable_b, enable_a}       <= bus.wr_data[1:0];
                            {sh_enable_b, sh_enable_a} <= bus.wr_data[1:0];
                        end
                    end
                    FREQ_A: sh_freq_a <= apply_strb(sh_freq_a, bus.wr_data, bus.wr_strb);
                    FREQ_B: sh_freq_b <= apply_strb(sh_freq_b, bus.wr_data, bus.wr_strb);
                    OFFSET: begin
                        {sh_offset_b, sh_offset_a} <=
                            apply_strb({sh_offset_b, sh_offset_a}, bus.wr_data, bus.wr_strb);
                    end
                    AMPLTD: begin
                        {sh_amp_b, sh_amp_a} <=
                            apply_strb({sh_amp_b, sh_amp_a}, bus.wr_data, bus.wr_strb);
                    end
                    RECONFIG: reconfig_busy <= 1'b1;
                    TRIGGER: begin
                        trigger_a <= bus.wr_data[0];
                        trigger_b <= bus.wr_data[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // ==================================================
    // Read mux, active values only
    // ==================================================
    always_comb begin
        bus.rd_data = '0;
        case (bus.rd_idx)
            MODE:   bus.rd_data[2*`WG_MODE_W-1:0] = {mode_b, mode_a};
            RUN:    bus.rd_data[1:0] = {enable_b, enable_a};
            FREQ_A: bus.rd_data = freq_a;
            FREQ_B: bus.rd_data = freq_b;
            OFFSET: bus.rd_data = {offset_b, offset_a};
            AMPLTD: bus.rd_data = {amp_b, amp_a};
            STATUS: begin
                bus.rd_data[3] = enable_b;
                bus.rd_data[2] = enable_a;
                bus.rd_data[1] = reconfig_busy;
                bus.rd_data[`WG_STATUS_READY] = 1'b1;
            end
            // TRIGGER, RECONFIG and reserved words
            default: bus.rd_data = '0;
        endcase
    end

    // Single-cycle control pulses
    a_trigger_pulse: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        (trigger_a || trigger_b) |=> !trigger_a && !trigger_b)
        else $error("ERROR %0t: trigger longer than one cycle", $time);

    a_busy_pulse: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        reconfig_busy |=> !reconfig_busy)
        else $error("ERROR %0t: reconfig_busy longer than one cycle", $time);

endmodule

//--- rtl/wavegen_scaler.sv
`timescale 1ns/1ps
`include "wavegen_cfg.svh"

module wavegen_scaler (
    input  logic                      axi_clk,
    input  logic                      axi_resetn,
    input  wavegen_chan_pkg::sample_t wave_a,
    input  wavegen_chan_pkg::sample_t wave_b,
    input  wavegen_chan_pkg::amp_t    amp_a,
    input  wavegen_chan_pkg::amp_t    amp_b,
    input  wavegen_chan_pkg::offset_t offset_a,
    input  wavegen_chan_pkg::offset_t offset_b,
    input  logic                      enable_a,
    input  logic                      enable_b,
    output wavegen_chan_pkg::sample_t out_a,
    output wavegen_chan_pkg::sample_t out_b
);
    import wavegen_chan_pkg::*;

    // Amplitude zero-extended so full Q1.15 range stays positive
    function automatic sample_t scale(sample_t wave, amp_t amp, offset_t offset);
        logic signed [2*`WG_SAMPLE_W:0] prod;
        logic signed [2*`WG_SAMPLE_W:0] shifted;
        prod    = $signed({1'b0, amp}) * wave;
        shifted = prod >>> `WG_AMP_FRAC;
        // Sum wraps to sample width
        return sample_t'(shifted[`WG_SAMPLE_W-1:0] + offset);
    endfunction

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            out_a <= '0;
            out_b <= '0;
        end else begin
            // Disabled channel parks at zero
            out_a <= enable_a ? scale(wave_a, amp_a, offset_a) : '0;
            out_b <= enable_b ? scale(wave_b, amp_b, offset_b) : '0;
        end
    end

endmodule

//--- rtl/wavegen_top.sv
`timescale 1ns/1ps

module wavegen_top (
    input  logic                       axi_clk,
    input  logic                       axi_resetn,
    input  wavegen_axi_pkg::axi_addr_t  awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  wavegen_axi_pkg::axi_data_t  wdata,
    input  wavegen_axi_pkg::axi_strb_t  wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output wavegen_axi_pkg::axi_resp_t  bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  wavegen_axi_pkg::axi_addr_t  araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output wavegen_axi_pkg::axi_data_t  rdata,
    output wavegen_axi_pkg::axi_resp_t  rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output wavegen_chan_pkg::mode_t     mode_a,
    output wavegen_chan_pkg::mode_t     mode_b,
    output wavegen_chan_pkg::freq_t     freq_a,
    output wavegen_chan_pkg::freq_t     freq_b,
    output logic                       trigger_a,
    output logic                       trigger_b,
    input  wavegen_chan_pkg::sample_t   wave_a,
    input  wavegen_chan_pkg::sample_t   wave_b,
    output wavegen_chan_pkg::sample_t   out_a,
    output wavegen_chan_pkg::sample_t   out_b
);
    import wavegen_chan_pkg::*;

    // Active settings feeding the output stage
    amp_t    amp_a, amp_b;
    offset_t offset_a, offset_b;
    logic    enable_a, enable_b;

    reg_bus_if u_bus ();

    wavegen_axi_slave u_axi_slave (
        .axi_clk    (axi_clk),
        .axi_resetn (axi_resetn),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .bus        (u_bus.master)
    );

    wavegen_regs u_regs (
        .axi_clk    (axi_clk),
        .axi_resetn (axi_resetn),
        .bus        (u_bus.target),
        .mode_a     (mode_a),
        .mode_b     (mode_b),
        .freq_a     (freq_a),
        .freq_b     (freq_b),
        .amp_a      (amp_a),
        .amp_b      (amp_b),
        .offset_a   (offset_a),
        .offset_b   (offset_b),
        .enable_a   (enable_a),
        .enable_b   (enable_b),
        .trigger_a  (trigger_a),
        .trigger_b  (trigger_b)
    );

    wavegen_scaler u_scaler (
        .axi_clk    (axi_clk),
        .axi_resetn (axi_resetn),
        .wave_a     (wave_a),
        .wave_b     (wave_b),
        .amp_a      (amp_a),
        .amp_b      (amp_b),
        .offset_a   (offset_a),
        .offset_b   (offset_b),
        .enable_a   (enable_a),
        .enable_b   (enable_b),
        .out_a      (out_a),
        .out_b      (out_b)
    );

endmodule

//--- verif/wavegen_tb.sv
`timescale 1ns/1ps

module wavegen_tb;
    import wavegen_axi_pkg::*;
    import wavegen_chan_pkg::*;

    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 50;

    logic      axi_clk;
    logic      axi_resetn;
    axi_addr_t awaddr, araddr;
    axi_data_t wdata, rdata;
    axi_strb_t wstrb;
    axi_resp_t bresp, rresp;
    logic      awvalid, awready, wvalid, wready, bvalid, bready;
    logic      arvalid, arready, rvalid, rready;
    mode_t     mode_a, mode_b;
    freq_t     freq_a, freq_b;
    logic      trigger_a, trigger_b;
    sample_t   wave_a, wave_b, out_a, out_b;

    integer seed;
    integer rnd;
    int     errors, test_errs, pass_count, fail_count;
    int     trig_a_seen, trig_b_seen;

    wavegen_top u_dut (.*);

    initial begin
        axi_clk = 1'b0;
        forever #20 axi_clk = ~axi_clk;
    end

    // Trigger pulses counted where they are stable
    always @(negedge axi_clk) begin
        if (trigger_a)
            trig_a_seen++;
        if (trigger_b)
            trig_b_seen++;
    end

    // ==================================================
    // Protocol assertions
    // ==================================================
    a_bvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        bvalid && !bready |=> bvalid)
        else begin
            $display("ERROR %0t: bvalid dropped without bready", $time);
            errors++;
        end

    a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        rvalid && !rready |=> rvalid)
        else begin
            $display("ERROR %0t: rvalid dropped without rready", $time);
            errors++;
        end

    // Address and data channels accepted in the same cycle
    a_wready_with_awready: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        wready == awready)
        else begin
            $display("ERROR %0t: wready is %b while awready is %b", $time, wready, awready);
            errors++;
        end

    // Every response is OKAY
    a_bresp_okay: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        bvalid |-> bresp == 2'b00)
        else begin
            $display("ERROR %0t: bresp is %b, expected OKAY", $time, bresp);
            errors++;
        end

    a_rresp_okay: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        rvalid |-> rresp == 2'b00)
        else begin
            $display("ERROR %0t: rresp is %b, expected OKAY", $time, rresp);
            errors++;
        end

    // No new address while a response waits
    a_no_accept_pending: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        (bvalid || rvalid) |-> !awready && !arready)
        else begin
            $display("ERROR %0t: address accepted during a pending response", $time);
            errors++;
        end

    a_trigger_b_once: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        trigger_b |=> !trigger_b)
        else begin
            $display("ERROR %0t: trigger_b longer than one cycle", $time);
            errors++;
        end

    // ==================================================
    // Helpers
    // ==================================================
    function automatic axi_addr_t reg_addr(input reg_idx_e idx);
        return axi_addr_t'({idx, 2'b00});
    endfunction

    // Expected sample as amp times wave shifted right by 15 plus offset
    function automatic sample_t expected_scaled(input sample_t wave, input amp_t amp,
                                                input offset_t offset);
        longint prod;
        longint sum;
        prod = longint'(wave) * longint'(amp);
        sum  = (prod >>> 15) + longint'(offset);
        return sample_t'(sum[15:0]);
    endfunction

    function automatic logic handshake_level(input string name);
        case (name)
            "awready": return awready;
            "bvalid":  return bvalid;
            "arready": return arready;
            "rvalid":  return rvalid;
            default:   return 1'b0;
        endcase
    endfunction

    task automatic wait_signal(input string name);
        int n;
        n = 0;
        while (!handshake_level(name) && n < WAIT_LIMIT) begin
            @(negedge axi_clk);
            n++;
        end
        if (!handshake_level(name)) begin
            $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, name);
            errors++;
        end
    endtask

    task automatic check_value(input string what, input axi_data_t got, input axi_data_t exp);
        assert (got === exp)
        else begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Starts and ends on a falling edge
    task automatic axi_write(input reg_idx_e idx, input axi_data_t data, input axi_strb_t strb);
        awaddr  = reg_addr(idx);
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        wait_signal("awready");
        // Accepted on the coming edge
        @(negedge axi_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_signal("bvalid");
        @(negedge axi_clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input reg_idx_e idx, output axi_data_t data);
        araddr  = reg_addr(idx);
        arvalid = 1'b1;
        rready  = 1'b1;
        wait_signal("arready");
        @(negedge axi_clk);
        arvalid = 1'b0;
        wait_signal("rvalid");
        data = rdata;
        @(negedge axi_clk);
        rready = 1'b0;
    endtask

    task automatic read_check(input reg_idx_e idx, input axi_data_t exp);
        axi_data_t d;
        axi_read(idx, d);
        check_value(idx.name(), d, exp);
    endtask

    task automatic end_test(input string name);
        if (errors == test_errs) begin
            pass_count++;
            $display("Test %s: pass", name);
        end else begin
            fail_count++;
            $display("Test %s: fail with %0d errors", name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        seed       = 32'h0aa0_84e2;
        errors     = 0;
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;
        axi_resetn = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        wave_a     = '0;
        wave_b     = '0;
        repeat (8) @(negedge axi_clk);
        axi_resetn = 1'b1;
        @(negedge axi_clk);

        // Reset defaults with full-scale amplitude and ready flag
        read_check(AMPLTD, 32'h7FFF_7FFF);
        read_check(MODE, 32'h0);
        read_check(RUN, 32'h0);
        read_check(FREQ_A, 32'h0);
        read_check(FREQ_B, 32'h0);
        read_check(STATUS, 32'h1);
        check_value("out_a", axi_data_t'(out_a), 32'h0);
        check_value("out_b", axi_data_t'(out_b), 32'h0);
        end_test("reset defaults");

        // Shadow writes stay hidden until RECONFIG
        axi_write(MODE, 32'h0000_0053, 4'hF);
        axi_write(FREQ_A, 32'h1234_5678, 4'hF);
        axi_write(OFFSET, 32'h0010_FF00, 4'hF);
        read_check(MODE, 32'h0);
        read_check(FREQ_A, 32'h0);
        read_check(OFFSET, 32'h0);
        check_value("mode_a", axi_data_t'(mode_a), 32'h0);
        check_value("freq_a", freq_a, 32'h0);
        axi_write(RECONFIG, 32'h1, 4'hF);
        read_check(MODE, 32'h0000_0053);
        read_check(FREQ_A, 32'h1234_5678);
        read_check(OFFSET, 32'h0010_FF00);
        check_value("mode_a", axi_data_t'(mode_a), 32'h3);
        check_value("mode_b", axi_data_t'(mode_b), 32'h5);
        check_value("freq_a", freq_a, 32'h1234_5678);
        end_test("shadow isolation");

        // Lanes 0 and 2 only
        axi_write(FREQ_B, 32'hAABB_CCDD, 4'b0101);
        axi_write(RECONFIG, 32'h1, 4'hF);
        read_check(FREQ_B, 32'h00BB_00DD);
        check_value("freq_b", freq_b, 32'h00BB_00DD);
        end_test("byte strobes");

        // Channel A at 0.75 scale with the -256 offset written above
        axi_write(AMPLTD, 32'h7FFF_6000, 4'hF);
        axi_write(RECONFIG, 32'h1, 4'hF);
        axi_write(RUN, 32'h1, 4'hF);
        read_check(STATUS, 32'h5);
        read_check(RUN, 32'h1);
        for (int i = 0; i < 32; i++) begin
            rnd    = $random(seed);
            wave_a = rnd[15:0];
            rnd    = $random(seed);
            wave_b = rnd[15:0];
            @(negedge axi_clk);
            assert (out_a === expected_scaled(wave_a, 16'h6000, 16'hFF00))
            else begin
                $display("ERROR %0t: out_a is %h for wave_a %h, expected %h", $time,
                         out_a, wave_a, expected_scaled(wave_a, 16'h6000, 16'hFF00));
                errors++;
            end
            assert (out_b === '0)
            else begin
                $display("ERROR %0t: out_b is %h on a disabled channel", $time, out_b);
                errors++;
            end
        end
        end_test("run and scaling");

        // One pulse on B only
        trig_a_seen = 0;
        trig_b_seen = 0;
        axi_write(TRIGGER, 32'h2, 4'hF);
        repeat (2) @(negedge axi_clk);
        check_value("trigger_b cycles", trig_b_seen, 32'd1);
        check_value("trigger_a cycles", trig_a_seen, 32'd0);
        read_check(TRIGGER, 32'h0);
        end_test("trigger");

        // First write parked in its response phase
        awaddr  = reg_addr(FREQ_A);
        wdata   = 32'hCAFE_0001;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        wait_signal("awready");
        @(negedge axi_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_signal("bvalid");
        // Second write offered meanwhile
        awaddr  = reg_addr(FREQ_B);
        wdata   = 32'hCAFE_0002;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        repeat (4) begin
            @(negedge axi_clk);
            assert (bvalid && !awready)
            else begin
                $display("ERROR %0t: write response not held under back-pressure", $time);
                errors++;
            end
        end
        bready = 1'b1;
        wait_signal("awready");
        @(negedge axi_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_signal("bvalid");
        @(negedge axi_clk);
        bready = 1'b0;
        axi_write(RECONFIG, 32'h1, 4'hF);
        read_check(FREQ_A, 32'hCAFE_0001);
        read_check(FREQ_B, 32'hCAFE_0002);
        // Read data parked until rready
        araddr  = reg_addr(FREQ_A);
        arvalid = 1'b1;
        rready  = 1'b0;
        wait_signal("arready");
        @(negedge axi_clk);
        arvalid = 1'b0;
        wait_signal("rvalid");
        repeat (4) begin
            @(negedge axi_clk);
            assert (rvalid && rdata === 32'hCAFE_0001)
            else begin
                $display("ERROR %0t: read data not held, rdata %h", $time, rdata);
                errors++;
            end
        end
        rready = 1'b1;
        @(negedge axi_clk);
        rready = 1'b0;
        check_value("rvalid after rready", axi_data_t'(rvalid), 32'h0);
        end_test("back-pressure");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/wavegen_axi_pkg.sv
rtl/wavegen_chan_pkg.sv
rtl/reg_bus_if.sv
rtl/wavegen_axi_slave.sv
rtl/wavegen_regs.sv
rtl/wavegen_scaler.sv
rtl/wavegen_top.sv
verif/wavegen_tb.sv

//--- Bender.yml
package:
  name: wavegen

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/wavegen_axi_pkg.sv
      - rtl/wavegen_chan_pkg.sv
      - rtl/reg_bus_if.sv
      - rtl/wavegen_axi_slave.sv
      - rtl/wavegen_regs.sv
      - rtl/wavegen_scaler.sv
      - rtl/wavegen_top.sv
  - target: test
    files:
      - verif/wavegen_tb.sv
